//--- design/acknowledge_sequencer.sv
/*
 * Acknowledge sequencer
 * Tracks INTA pulses and poll reads, raises INT and freezes the request logic
 */
module acknowledge_sequencer (
    input  logic               clock,
    input  logic               reset,
    input  logic               inta_n,
    input  logic               read,
    input  logic               poll_request,
    input  logic               write_ocw2,
    input  pic_pkg::irq_vec_t  interrupt,
    icw_config_if.seq_dst      cfg,
    ack_event_if.src           ack,
    output logic               interrupt_to_cpu,
    output logic               freeze
);
    import pic_pkg::*;

    logic       prev_inta_n;
    logic       prev_read;
    logic       inta_fall;
    logic       inta_rise;
    logic       read_fall;
    logic       ocw2_block;
    ctl_state_t state;
    ctl_state_t next_state;

    always_ff @(posedge clock) begin
        if (reset) begin
            prev_inta_n <= 1'b1;
            prev_read   <= 1'b0;
        end else begin
            prev_inta_n <= inta_n;
            prev_read   <= read;
        end
    end

    assign inta_fall  = prev_inta_n && !inta_n;
    assign inta_rise  = !prev_inta_n && inta_n;
    assign read_fall  = prev_read && !read;
    assign ocw2_block = write_ocw2 && cfg.in_ready;

    always_comb begin
        next_state = state;
        case (state)
            READY: begin
                if (poll_request)
                    next_state = POLL;
                else if (inta_fall && !ocw2_block)
                    next_state = ACK1;
            end
            ACK1: begin
                if (inta_rise)
                    next_state = ACK2;
            end
            // 8086 ends after two pulses, MCS-80 takes a third
            ACK2: begin
                if (inta_rise)
                    next_state = cfg.mode_8086 ? READY : ACK3;
            end
            ACK3: begin
                if (inta_rise)
                    next_state = READY;
            end
            POLL: begin
                if (read_fall)
                    next_state = READY;
            end
            default: next_state = READY;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset)
            state <= READY;
        else
            state <= next_state;
    end

    assign ack.ctl_state          = state;
    assign ack.latch_in_service   = (state == READY) && (next_state != READY);
    assign ack.end_of_acknowledge = (state inside {ACK1, ACK2, ACK3}) && (next_state == READY);
    assign ack.end_of_poll        = (state == POLL) && (next_state == READY);

    always_ff @(posedge clock) begin
        if (reset)
            interrupt_to_cpu <= 1'b0;
        else if (interrupt != '0)
            interrupt_to_cpu <= 1'b1;
        else if (ack.end_of_acknowledge || ack.end_of_poll)
            interrupt_to_cpu <= 1'b0;
    end

    // Held while a sequence is running
    always_ff @(posedge clock) begin
        if (reset)
            freeze <= 1'b1;
        else
            freeze <= (next_state != READY);
    end

endmodule

//--- design/init_command_regs.sv
/*
 * Initialization command registers
 * Steps through ICW1, ICW2 and the optional ICW4, holding their fields
 */
module init_command_regs (
    input  logic             clock,
    input  logic             reset,
    input  logic [7:0]       data,
    input  logic             write_icw1,
    input  logic             write_icw2_4,
    icw_config_if.src        cfg,
    output logic             level_or_edge_config,
    output logic             special_fully_nest_config
);
    import pic_pkg::*;

    cmd_state_t state;
    cmd_state_t next_state;
    logic       set_icw4;
    logic       write_icw2;
    logic       write_icw4;

    // ICW3 never expected in a single device
    always_comb begin
        next_state = state;
        if (write_icw1)
            next_state = WRITE_ICW2;
        else if (write_icw2_4) begin
            if (state == WRITE_ICW2 && set_icw4)
                next_state = WRITE_ICW4;
            else
                next_state = CMD_READY;
        end
    end

    always_ff @(posedge clock) begin
        if (reset)
            state <= CMD_READY;
        else
            state <= next_state;
    end

    assign write_icw2      = (state == WRITE_ICW2) && write_icw2_4;
    assign write_icw4      = (state == WRITE_ICW4) && write_icw2_4;
    assign cfg.in_ready    = (state == CMD_READY);
    assign cfg.icw1_strobe = write_icw1;

    // A7..A5 from ICW1, A15..A8 from ICW2
    always_ff @(posedge clock) begin
        if (write_icw1)
            cfg.vector_address[2:0] <= data[7:5];
        if (write_icw2)
            cfg.vector_address[10:3] <= data;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            level_or_edge_config <= 1'b0;
            cfg.call_interval_4  <= 1'b0;
            set_icw4             <= 1'b0;
        end else if (write_icw1) begin
            level_or_edge_config <= data[ICW1_LTIM];
            cfg.call_interval_4  <= data[ICW1_ADI];
            set_icw4             <= data[ICW1_IC4];
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            special_fully_nest_config <= 1'b0;
            cfg.auto_eoi              <= 1'b0;
            cfg.mode_8086             <= 1'b0;
        end else if (write_icw4) begin
            special_fully_nest_config <= data[ICW4_SFNM];
            cfg.auto_eoi              <= data[ICW4_AEOI];
            cfg.mode_8086             <= data[ICW4_UPM];
        end
    end

endmodule

//--- design/operation_command_regs.sv
/*
 * Operation command registers
 * Interrupt mask, EOI and rotation from OCW2, read select and poll from OCW3
 */
module operation_command_regs (
    input  logic               clock,
    input  logic               reset,
    input  logic [7:0]         data,
    input  logic               write_ocw1,
    input  logic               write_ocw2,
    input  logic               write_ocw3,
    icw_config_if.ocw_dst      cfg,
    ack_event_if.ocw_dst       ack,
    input  pic_pkg::irq_vec_t  acknowledged,
    input  pic_pkg::irq_vec_t  highest_level_in_service,
    input  pic_pkg::irq_vec_t  interrupt,
    output pic_pkg::irq_vec_t  interrupt_mask,
    output pic_pkg::irq_vec_t  end_of_interrupt,
    output pic_pkg::irq_vec_t  clear_interrupt_request,
    output pic_pkg::level_t    priority_rotate,
    output logic               enable_read_register,
    output logic               read_register_isr,
    output logic               poll_request
);
    import pic_pkg::*;

    logic       ocw2_write;
    logic       ocw3_write;
    logic [2:0] ocw2_code;
    level_t     spec_level;
    logic       auto_rotate_mode;

    assign ocw2_write = write_ocw2 && cfg.in_ready;
    assign ocw3_write = write_ocw3 && cfg.in_ready;
    assign ocw2_code  = data[OCW2_CODE_LSB +: 3];
    assign spec_level = data[2:0];

    always_ff @(posedge clock) begin
        if (reset)
            interrupt_mask <= '1;
        else if (write_ocw1 && cfg.in_ready)
            interrupt_mask <= data;
    end

    // Automatic EOI takes priority over a command in the same cycle
    always_comb begin
        end_of_interrupt = '0;
        if (cfg.auto_eoi && ack.end_of_acknowledge)
            end_of_interrupt = acknowledged;
        else if (ocw2_write) begin
            casez (ocw2_code)
                3'b?01:  end_of_interrupt = highest_level_in_service;
                3'b?11:  end_of_interrupt = num2bit(spec_level);
                default: end_of_interrupt = '0;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (reset)
            auto_rotate_mode <= 1'b0;
        else if (ocw2_write && ocw2_code == 3'b000)
            auto_rotate_mode <= 1'b0;
        else if (ocw2_write && ocw2_code == 3'b100)
            auto_rotate_mode <= 1'b1;
    end

    always_ff @(posedge clock) begin
        if (reset)
            priority_rotate <= 3'd7;
        else if (auto_rotate_mode && ack.end_of_acknowledge)
            priority_rotate <= bit2num(acknowledged);
        else if (ocw2_write && ocw2_code == 3'b101)
            priority_rotate <= bit2num(highest_level_in_service);
        else if (ocw2_write && ocw2_code[2:1] == 2'b11)
            priority_rotate <= spec_level;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            enable_read_register <= 1'b1;
            read_register_isr    <= 1'b0;
        end else if (ocw3_write) begin
            enable_read_register <= data[OCW3_RR];
            read_register_isr    <= data[OCW3_RIS];
        end
    end

    assign poll_request = ocw3_write && data[OCW3_P];

    always_comb begin
        if (cfg.icw1_strobe)
            clear_interrupt_request = '1;
        else if (ack.latch_in_service)
            clear_interrupt_request = interrupt;
        else
            clear_interrupt_request = '0;
    end

endmodule

//--- design/pic_control_logic.sv
/*
 * PIC control logic
 * Command decode and INTA handling for an 8259-style interrupt controller
 */
module pic_control_logic (
    input  logic               clock,
    input  logic               reset,
    input  logic [7:0]         internal_data_bus,
    input  logic               write_icw1,
    input  logic               write_icw2_4,
    input  logic               write_ocw1,
    input  logic               write_ocw2,
    input  logic               write_ocw3,
    input  logic               interrupt_acknowledge_n,
    input  logic               read,
    input  pic_pkg::irq_vec_t  interrupt,
    input  pic_pkg::irq_vec_t  highest_level_in_service,
    output logic               interrupt_to_cpu,
    output logic               out_control_logic_data,
    output logic [7:0]         control_logic_data,
    output logic               level_or_edge_config,
    output logic               special_fully_nest_config,
    output logic               enable_read_register,
    output logic               read_register_isr,
    output pic_pkg::irq_vec_t  interrupt_mask,
    output pic_pkg::irq_vec_t  end_of_interrupt,
    output pic_pkg::irq_vec_t  clear_interrupt_request,
    output pic_pkg::level_t    priority_rotate,
    output logic               freeze
);
    import pic_pkg::*;

    irq_vec_t acknowledged;
    logic     poll_request;

    icw_config_if cfg_if ();
    ack_event_if  ack_if ();

    init_command_regs u_icw (
        .clock                    (clock),
        .reset                    (reset),
        .data                     (internal_data_bus),
        .write_icw1               (write_icw1),
        .write_icw2_4             (write_icw2_4),
        .cfg                      (cfg_if.src),
        .level_or_edge_config     (level_or_edge_config),
        .special_fully_nest_config(special_fully_nest_config)
    );

    operation_command_regs u_ocw (
        .clock                   (clock),
        .reset                   (reset),
        .data                    (internal_data_bus),
        .write_ocw1              (write_ocw1),
        .write_ocw2              (write_ocw2),
        .write_ocw3              (write_ocw3),
        .cfg                     (cfg_if.ocw_dst),
        .ack                     (ack_if.ocw_dst),
        .acknowledged            (acknowledged),
        .highest_level_in_service(highest_level_in_service),
        .interrupt               (interrupt),
        .interrupt_mask          (interrupt_mask),
        .end_of_interrupt        (end_of_interrupt),
        .clear_interrupt_request (clear_interrupt_request),
        .priority_rotate         (priority_rotate),
        .enable_read_register    (enable_read_register),
        .read_register_isr       (read_register_isr),
        .poll_request            (poll_request)
    );

    acknowledge_sequencer u_seq (
        .clock           (clock),
        .reset           (reset),
        .inta_n          (interrupt_acknowledge_n),
        .read            (read),
        .poll_request    (poll_request),
        .write_ocw2      (write_ocw2),
        .interrupt       (interrupt),
        .cfg             (cfg_if.seq_dst),
        .ack             (ack_if.src),
        .interrupt_to_cpu(interrupt_to_cpu),
        .freeze          (freeze)
    );

    vector_output u_vec (
        .clock                 (clock),
        .reset                 (reset),
        .inta_n                (interrupt_acknowledge_n),
        .read                  (read),
        .interrupt             (interrupt),
        .cfg                   (cfg_if.vec_dst),
        .ack                   (ack_if.vec_dst),
        .acknowledged          (acknowledged),
        .out_control_logic_data(out_control_logic_data),
        .control_logic_data    (control_logic_data)
    );

endmodule

//--- design/pic_intf.sv
/*
 * PIC internal interfaces
 * Initialization config from the ICW block, acknowledge events from the sequencer
 */
interface icw_config_if;

    logic [10:0] vector_address;
    logic        call_interval_4;
    logic        auto_eoi;
    logic        mode_8086;
    logic        in_ready;
    logic        icw1_strobe;

    modport src (
        output vector_address, call_interval_4, auto_eoi, mode_8086, in_ready, icw1_strobe
    );
    modport ocw_dst (input in_ready, auto_eoi, icw1_strobe);
    modport vec_dst (input vector_address, call_interval_4, mode_8086);
    modport seq_dst (input mode_8086, in_ready);

endinterface

interface ack_event_if;
    import pic_pkg::*;

    ctl_state_t ctl_state;
    logic       latch_in_service;
    logic       end_of_acknowledge;
    logic       end_of_poll;

    modport src (output ctl_state, latch_in_service, end_of_acknowledge, end_of_poll);
    modport ocw_dst (input latch_in_service, end_of_acknowledge);
    modport vec_dst (input ctl_state, latch_in_service, end_of_acknowledge, end_of_poll);

endinterface

//--- design/pic_pkg.sv
/*
 * PIC control package
 * Command word bit positions, state encodings and level conversions
 */
package pic_pkg;

    typedef logic [2:0] level_t;
    typedef logic [7:0] irq_vec_t;

    typedef enum logic [2:0] {READY, ACK1, ACK2, ACK3, POLL} ctl_state_t;
    typedef enum logic [1:0] {CMD_READY, WRITE_ICW2, WRITE_ICW4} cmd_state_t;

    // MCS-80 CALL instruction
    localparam logic [7:0] CALL_OPCODE = 8'hcd;
    localparam int POLL_FLAG_BIT = 7;

    localparam int ICW1_LTIM = 3;
    localparam int ICW1_ADI  = 2;
    localparam int ICW1_IC4  = 0;
    localparam int ICW4_SFNM = 4;
    localparam int ICW4_AEOI = 1;
    localparam int ICW4_UPM  = 0;
    // R, SL and EOI sit in bits 7..5
    localparam int OCW2_CODE_LSB = 5;
    localparam int OCW3_P   = 2;
    localparam int OCW3_RR  = 1;
    localparam int OCW3_RIS = 0;

    function automatic irq_vec_t num2bit(input level_t level);
        irq_vec_t vec;
        vec = '0;
        vec[level] = 1'b1;
        return vec;
    endfunction

    // Lowest set line wins
    function automatic level_t bit2num(input irq_vec_t vec);
        level_t level;
        level = '0;
        for (int i = 7; i >= 0; i--) begin
            if (vec[i])
                level = level_t'(i);
        end
        return level;
    endfunction

endpackage

//--- design/vector_output.sv
/*
 * Vector output
 * Holds the acknowledged line and drives CALL, vector and poll bytes
 */
module vector_output (
    input  logic               clock,
    input  logic               reset,
    input  logic               inta_n,
    input  logic               read,
    input  pic_pkg::irq_vec_t  interrupt,
    icw_config_if.vec_dst      cfg,
    ack_event_if.vec_dst       ack,
    output pic_pkg::irq_vec_t  acknowledged,
    output logic               out_control_logic_data,
    output logic [7:0]         control_logic_data
);
    import pic_pkg::*;

    level_t level;

    always_ff @(posedge clock) begin
        if (reset)
            acknowledged <= '0;
        else if (ack.end_of_acknowledge || ack.end_of_poll)
            acknowledged <= '0;
        else if (ack.latch_in_service)
            acknowledged <= interrupt;
    end

    assign level = bit2num(acknowledged);

    always_comb begin
        out_control_logic_data = 1'b0;
        control_logic_data     = '0;
        if (!inta_n) begin
            case (ack.ctl_state)
                // First pulse drives nothing in 8086 mode
                READY, ACK1: begin
                    if (!cfg.mode_8086) begin
                        out_control_logic_data = 1'b1;
                        control_logic_data     = CALL_OPCODE;
                    end
                end
                ACK2: begin
                    out_control_logic_data = 1'b1;
                    if (cfg.mode_8086)
                        control_logic_data = {cfg.vector_address[10:6], level};
                    else if (cfg.call_interval_4)
                        control_logic_data = {cfg.vector_address[2:0], level, 2'b00};
                    else
                        control_logic_data = {cfg.vector_address[2:1], level, 3'b000};
                end
                ACK3: begin
                    out_control_logic_data = 1'b1;
                    control_logic_data     = cfg.vector_address[10:3];
                end
                default: ;
            endcase
        end else if (ack.ctl_state == POLL && read) begin
            out_control_logic_data = 1'b1;
            if (acknowledged != '0) begin
                control_logic_data[POLL_FLAG_BIT] = 1'b1;
                control_logic_data[2:0]           = level;
            end
        end
    end

endmodule

//--- dv/pic_control_logic_sva.sv
/*
 * PIC control checker
 * Data drive, INT, clear strobe and freeze rules, bound into the control logic
 */
module pic_control_logic_sva (
    input logic                clock,
    input logic                reset,
    input logic                write_icw1,
    input logic                interrupt_acknowledge_n,
    input logic                read,
    input pic_pkg::irq_vec_t   interrupt,
    input pic_pkg::irq_vec_t   clear_interrupt_request,
    input logic                interrupt_to_cpu,
    input logic                out_control_logic_data,
    input logic                freeze,
    input pic_pkg::ctl_state_t ctl_state
);
    timeunit 1ns;
    timeprecision 100ps;
    import pic_pkg::*;

    int unsigned error_count = 0;

    // Bus stays quiet when idle with no INTA and no read
    idle_no_drive: assert property (@(posedge clock) disable iff (reset)
        (ctl_state == READY && interrupt_acknowledge_n && !read) |-> !out_control_logic_data)
    else begin
        error_count++;
        $error("data driven while idle without INTA or read");
    end

    int_follows_request: assert property (@(posedge clock) disable iff (reset)
        (interrupt != '0) |=> interrupt_to_cpu)
    else begin
        error_count++;
        $error("interrupt_to_cpu did not rise after a pending interrupt");
    end

    icw1_clears_requests: assert property (@(posedge clock) disable iff (reset)
        write_icw1 |-> (clear_interrupt_request == 8'hff))
    else begin
        error_count++;
        $error("ICW1 did not clear every request line");
    end

    // Freeze is still high in the first cycle out of reset
    ready_not_frozen: assert property (@(posedge clock) disable iff (reset)
        (ctl_state == READY && !$past(reset)) |-> !freeze)
    else begin
        error_count++;
        $error("freeze high while the sequencer is ready");
    end

endmodule

//--- dv/pic_control_logic_tb.sv
/*
 * PIC control logic testbench
 * Initialization, 8086 and MCS-80 acknowledge, EOI, rotation and poll
 */
module pic_control_logic_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import pic_pkg::*;

    // About twice the length of all tests
    localparam int MAX_CYCLES = 150;

    typedef enum int {ICW1, ICW2_4, OCW1, OCW2, OCW3} word_t;

    logic       clock;
    logic       reset;
    logic [7:0] internal_data_bus;
    logic       write_icw1;
    logic       write_icw2_4;
    logic       write_ocw1;
    logic       write_ocw2;
    logic       write_ocw3;
    logic       interrupt_acknowledge_n;
    logic       read;
    irq_vec_t   interrupt;
    irq_vec_t   highest_level_in_service;
    logic       interrupt_to_cpu;
    logic       out_control_logic_data;
    logic [7:0] control_logic_data;
    logic       level_or_edge_config;
    logic       special_fully_nest_config;
    logic       enable_read_register;
    logic       read_register_isr;
    irq_vec_t   interrupt_mask;
    irq_vec_t   end_of_interrupt;
    irq_vec_t   clear_interrupt_request;
    level_t     priority_rotate;
    logic       freeze;

    logic [31:0] lfsr_state;
    int unsigned cycle_count = 0;
    logic [7:0]  seen_data [3];
    logic        seen_drive [3];
    irq_vec_t    seen_clear;
    irq_vec_t    seen_eoi;

    pic_control_logic dut (.*);

    bind pic_control_logic pic_control_logic_sva u_sva (
        .clock                  (clock),
        .reset                  (reset),
        .write_icw1             (write_icw1),
        .interrupt_acknowledge_n(interrupt_acknowledge_n),
        .read                   (read),
        .interrupt              (interrupt),
        .clear_interrupt_request(clear_interrupt_request),
        .interrupt_to_cpu       (interrupt_to_cpu),
        .out_control_logic_data (out_control_logic_data),
        .freeze                 (freeze),
        .ctl_state              (ack_if.ctl_state)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: no result after %0d cycles", MAX_CYCLES);
            stop_run();
        end
    end

    task automatic stop_run();
        $display("Test failed");
        $fatal(1, "Run stopped on error");
    endtask

    task automatic check(input string name, input logic [7:0] expected, input logic [7:0] actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            stop_run();
        end
    endtask

    function automatic logic [31:0] galois_step(input logic [31:0] state);
        logic [31:0] next;
        next = state >> 1;
        if (state[0])
            next = next ^ 32'h80200003;
        return next;
    endfunction

    task automatic random_bits(input int count, output logic [7:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[6:0], lfsr_state[0]};
            lfsr_state = galois_step(lfsr_state);
        end
    endtask

    task automatic release_strobes();
        write_icw1   = 1'b0;
        write_icw2_4 = 1'b0;
        write_ocw1   = 1'b0;
        write_ocw2   = 1'b0;
        write_ocw3   = 1'b0;
    endtask

    // Strobe stays up for one rising edge until the next drive task clears it
    task automatic write_word(input word_t kind, input logic [7:0] value);
        @(negedge clock);
        release_strobes();
        internal_data_bus = value;
        case (kind)
            ICW1:    write_icw1   = 1'b1;
            ICW2_4:  write_icw2_4 = 1'b1;
            OCW1:    write_ocw1   = 1'b1;
            OCW2:    write_ocw2   = 1'b1;
            default: write_ocw3   = 1'b1;
        endcase
        #2;
    endtask

    task automatic next_cycle();
        @(negedge clock);
        release_strobes();
        #2;
    endtask

    task automatic drive_levels(input irq_vec_t irq, input irq_vec_t in_service);
        @(negedge clock);
        release_strobes();
        interrupt                = irq;
        highest_level_in_service = in_service;
        #2;
    endtask

    task automatic inta_pulse(input int index);
        @(negedge clock);
        release_strobes();
        interrupt_acknowledge_n = 1'b0;
        #2;
        seen_data[index]  = control_logic_data;
        seen_drive[index] = out_control_logic_data;
        if (index == 0)
            seen_clear = clear_interrupt_request;
        // Request drops once the controller has taken it
        @(negedge clock);
        interrupt_acknowledge_n = 1'b1;
        interrupt               = '0;
        #2;
        seen_eoi = end_of_interrupt;
    endtask

    task automatic acknowledge(input irq_vec_t irq, input int pulses);
        drive_levels(irq, '0);
        next_cycle();
        check("int raised", 8'h01, {7'b0, interrupt_to_cpu});
        for (int i = 0; i < pulses; i++)
            inta_pulse(i);
        next_cycle();
        check("int dropped", 8'h00, {7'b0, interrupt_to_cpu});
    endtask

    task automatic mcs80(input logic adi);
        logic [7:0] addr;
        logic [7:0] base;
        logic [7:0] rnd;
        level_t     level;
        logic [7:0] low_byte;
        random_bits(3, addr);
        random_bits(8, base);
        random_bits(3, rnd);
        level = rnd[2:0];
        write_word(ICW1, {addr[2:0], 2'b10, adi, 2'b11});
        write_word(ICW2_4, base);
        write_word(ICW2_4, 8'h00);
        // Interval 4 keeps A5, interval 8 gives it to the level
        if (adi)
            low_byte = {addr[2:0], level, 2'b00};
        else
            low_byte = {addr[2:1], level, 3'b000};
        acknowledge(8'h01 << level, 3);
        check("mcs80 call opcode", 8'hcd, seen_data[0]);
        check("mcs80 low address", low_byte, seen_data[1]);
        check("mcs80 high address", base, seen_data[2]);
    endtask

    task automatic poll_read(input irq_vec_t irq, input logic [7:0] expected);
        drive_levels(irq, '0);
        write_word(OCW3, 8'h0c);
        @(negedge clock);
        release_strobes();
        read = 1'b1;
        #2;
        check("poll drive", 8'h01, {7'b0, out_control_logic_data});
        check("poll byte", expected, control_logic_data);
        check("poll freeze", 8'h01, {7'b0, freeze});
        @(negedge clock);
        read = 1'b0;
        next_cycle();
        check("poll back to ready", 8'h00, {7'b0, freeze});
    endtask

    initial begin
        logic [7:0] base;
        logic [7:0] rnd;
        level_t     level;
        reset                    = 1'b1;
        internal_data_bus        = '0;
        interrupt_acknowledge_n  = 1'b1;
        read                     = 1'b0;
        interrupt                = '0;
        highest_level_in_service = '0;
        lfsr_state               = 32'hf670;
        release_strobes();
        repeat (2) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        #2;
        check("reset freeze", 8'h01, {7'b0, freeze});
        check("reset int", 8'h00, {7'b0, interrupt_to_cpu});
        check("reset data drive", 8'h00, {7'b0, out_control_logic_data});
        check("reset eoi", 8'h00, end_of_interrupt);
        check("reset clear", 8'h00, clear_interrupt_request);
        check("reset mask", 8'hff, interrupt_mask);
        check("reset rotate", 8'h07, {5'b0, priority_rotate});
        check("reset read select", 8'h01, {7'b0, enable_read_register});
        next_cycle();
        check("freeze released", 8'h00, {7'b0, freeze});

        random_bits(3, rnd);
        random_bits(8, base);
        write_word(ICW1, {rnd[2:0], 5'b11011});
        check("icw1 clear", 8'hff, clear_interrupt_request);
        write_word(ICW2_4, base);
        check("icw1 ltim", 8'h01, {7'b0, level_or_edge_config});
        write_word(ICW2_4, 8'h11);
        random_bits(8, rnd);
        write_word(OCW1, rnd);
        check("icw4 sfnm", 8'h01, {7'b0, special_fully_nest_config});
        next_cycle();
        check("ocw1 mask", rnd, interrupt_mask);

        random_bits(3, rnd);
        level = rnd[2:0];
        acknowledge(8'h01 << level, 2);
        check("8086 first pulse drive", 8'h00, {7'b0, seen_drive[0]});
        check("8086 latch clear", 8'h01 << level, seen_clear);
        check("8086 vector drive", 8'h01, {7'b0, seen_drive[1]});
        check("8086 vector", {base[7:3], level}, seen_data[1]);

        mcs80(1'b0);
        mcs80(1'b1);

        random_bits(3, rnd);
        level = rnd[2:0];
        drive_levels('0, 8'h01 << level);
        write_word(OCW2, 8'h20);
        check("non-specific eoi", 8'h01 << level, end_of_interrupt);
        random_bits(3, rnd);
        level = rnd[2:0];
        write_word(OCW2, {5'b01100, level});
        check("specific eoi", 8'h01 << level, end_of_interrupt);
        random_bits(3, rnd);
        level = rnd[2:0];
        write_word(OCW2, {5'b11100, level});
        next_cycle();
        check("rotate on specific", {5'b0, level}, {5'b0, priority_rotate});

        // 8086 mode with AEOI, then automatic rotate on
        write_word(ICW1, 8'h13);
        write_word(ICW2_4, base);
        write_word(ICW2_4, 8'h03);
        write_word(OCW2, 8'h80);
        random_bits(3, rnd);
        level = rnd[2:0];
        acknowledge(8'h01 << level, 2);
        check("auto eoi", 8'h01 << level, seen_eoi);
        check("auto rotate", {5'b0, level}, {5'b0, priority_rotate});

        random_bits(3, rnd);
        level = rnd[2:0];
        poll_read(8'h01 << level, {1'b1, 4'b0000, level});
        poll_read('0, 8'h00);
        check("int after poll", 8'h00, {7'b0, interrupt_to_cpu});

        // Read select back on with ISR chosen
        write_word(OCW3, 8'h0b);
        next_cycle();
        check("read select", 8'h01, {7'b0, enable_read_register});
        check("read isr select", 8'h01, {7'b0, read_register_isr});

        if (dut.u_sva.error_count != 0) begin
            $display("Bound assertions reported %0d errors", dut.u_sva.error_count);
            stop_run();
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

//--- flist.f
design/pic_pkg.sv
design/pic_intf.sv
design/init_command_regs.sv
design/operation_command_regs.sv
design/acknowledge_sequencer.sv
design/vector_output.sv
design/pic_control_logic.sv
dv/pic_control_logic_sva.sv
dv/pic_control_logic_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the PIC control logic testbench with Verilator

verilator --binary --assert --timescale 1ns/100ps \
    --top-module pic_control_logic_tb -f flist.f \
    && { ./obj_dir/Vpic_control_logic_tb > sim.log 2>&1 || true; } \
    && cat sim.log \
    && ! grep -q "Test failed" sim.log \
    && grep -q "Test passed" sim.log \
    || exit 1
